/* include/console_defs.svh */
`ifndef CONSOLE_DEFS_SVH
`define CONSOLE_DEFS_SVH

// Screen geometry
`define CON_COLS       32
`define CON_ROWS       19
`define CON_CELLS      608

// Teletype control codes
`define CON_AT         22  // Followed by row, then column
`define CON_CR         13
`define CON_HOME       12  // Clear screen, cursor to 0

`define CON_STR_END    255 // String terminator in the table
`define CON_SPACE      32

// ------------------------------
// Report layout
// ------------------------------
`define CON_ROW_MODE   3
`define CON_COL_MODE   10
`define CON_ROW_DNA    4
`define CON_COL_DNA    10
`define CON_ROW_MEM    6
`define CON_ROW_SDRAM  11
`define CON_ROW_SD     12
`define CON_ROW_FLASH  13
`define CON_COL_TEST   21  // Same column for every test result

`define CON_DNA_DIGITS 15

`endif

/* hdl/console_pkg.sv */
package console_pkg;

   typedef logic [7:0] char_t;
   typedef logic [9:0] cell_addr_t;  // Row * 32 + column
   typedef logic [6:0] str_addr_t;

   // One byte on the reporter to teletype link
   // Read as a character code, or as a coordinate after AT
   typedef union packed {
      char_t code;
      struct packed {
         logic [2:0] pad;
         logic [4:0] pos;  // Row or column
      } coord;
   } tele_byte_u;

   // Buffer write port
   typedef struct packed {
      logic       en;
      cell_addr_t addr;
      char_t      data;
   } buf_write_t;

   typedef struct packed {
      logic progress;  // Test still running
      logic result;    // 1 = pass
   } test_status_t;

   typedef struct packed {
      logic vga;
      logic ntsc;
   } video_sel_t;

   // Everything the status screen reports
   typedef struct packed {
      video_sel_t   video;
      logic [56:0]  dna;    // Device ID
      test_status_t mem;
      test_status_t sdram;
      test_status_t sd;
      test_status_t flash;
   } report_in_t;

endpackage

/* hdl/screen_buffer.sv */
`timescale 1ns/1ps

`include "console_defs.svh"

module screen_buffer (
   input  logic                    clk,
   input  console_pkg::buf_write_t wr,
   input  console_pkg::cell_addr_t read_addr,
   output console_pkg::char_t      read_char
);
   import console_pkg::*;

   // 32 x 19 text cells
   char_t mem [`CON_CELLS];

   // Teletype side
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // Renderer fetch port, one cycle latency
   always_ff @(posedge clk) begin
      read_char <= mem[read_addr];
   end

endmodule

/* hdl/teletype.sv */
`timescale 1ns/1ps

`include "console_defs.svh"

module teletype (
   input  logic                    clk,
   input  logic                    arst_n,
   input  console_pkg::tele_byte_u tty_byte,
   input  logic                    tty_valid,
   output logic                    tty_credit,
   output console_pkg::buf_write_t wr
);
   import console_pkg::*;

   localparam char_t      CODE_AT    = 8'd`CON_AT;
   localparam char_t      CODE_CR    = 8'd`CON_CR;
   localparam char_t      CODE_HOME  = 8'd`CON_HOME;
   localparam char_t      CODE_SPACE = 8'd`CON_SPACE;
   localparam cell_addr_t LAST_CELL  = cell_addr_t'(`CON_CELLS - 1);
   localparam logic [4:0] LAST_ROW   = 5'(`CON_ROWS - 1);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ROW,    // Waiting for row byte after AT
      ST_COL,    // Waiting for column byte
      ST_CLEAR,
      ST_WRITE
   } tty_state_t;

   tty_state_t state;
   cell_addr_t cursor;
   cell_addr_t next_cell;
   logic [4:0] row;
   logic [4:0] next_row;

   // Cursor wraps at the end of the screen
   assign next_row  = (cursor[9:5] == LAST_ROW) ? 5'd0 : cursor[9:5] + 5'd1;
   assign next_cell = (cursor == LAST_CELL) ? '0 : cursor + 10'd1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ST_IDLE;
         cursor     <= '0;
         row        <= '0;
         tty_credit <= 1'b0;
         wr         <= '0;
      end else begin
         tty_credit <= 1'b0;  // Single-cycle pulse
         case (state)
            ST_IDLE: begin
               if (tty_valid) begin
                  case (tty_byte.code)
                     CODE_AT: begin
                        tty_credit <= 1'b1;
                        state      <= ST_ROW;
                     end
                     CODE_CR: begin
                        cursor     <= {next_row, 5'd0};
                        tty_credit <= 1'b1;
                     end
                     CODE_HOME: begin
                        wr.en   <= 1'b1;  // Sweep starts at cell 0
                        wr.addr <= '0;
                        wr.data <= CODE_SPACE;
                        state   <= ST_CLEAR;
                     end
                     default: begin
                        wr.en      <= 1'b1;
                        wr.addr    <= cursor;
                        wr.data    <= tty_byte.code;
                        tty_credit <= 1'b1;  // Same cycle as the write
                        state      <= ST_WRITE;
                     end
                  endcase
               end
            end

            ST_ROW: begin
               if (tty_valid) begin
                  row        <= tty_byte.coord.pos;
                  tty_credit <= 1'b1;
                  state      <= ST_COL;
               end
            end

            ST_COL: begin
               if (tty_valid) begin
                  cursor     <= {row, tty_byte.coord.pos};
                  tty_credit <= 1'b1;
                  state      <= ST_IDLE;
               end
            end

            // One cell per cycle, 608 writes in a row
            ST_CLEAR: begin
               if (wr.addr == LAST_CELL) begin
                  wr.en      <= 1'b0;
                  cursor     <= '0;
                  tty_credit <= 1'b1;
                  state      <= ST_IDLE;
               end else begin
                  wr.addr <= wr.addr + 10'd1;
               end
            end

            ST_WRITE: begin
               wr.en  <= 1'b0;
               cursor <= next_cell;
               state  <= ST_IDLE;
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* hdl/string_table.sv */
`timescale 1ns/1ps

`include "console_defs.svh"

module string_table (
   input  console_pkg::str_addr_t addr,
   input  logic [3:0]             digit,
   output console_pkg::char_t     data,
   output console_pkg::char_t     glyph
);
   import console_pkg::*;

   localparam char_t END_CHAR = 8'd`CON_STR_END;
   localparam char_t AT_CHAR  = 8'd`CON_AT;
   localparam char_t ZERO     = "0";
   localparam char_t ALPHA    = "A" - 8'd10;  // Offset so digit 10 maps to A

   // ------------------------------
   // Position strings at 0..23
   // ------------------------------
   // Four bytes each: AT, row, column, terminator
   localparam logic [0:5][0:1][7:0] POS_RC = {
      {8'd`CON_ROW_MODE,  8'd`CON_COL_MODE},
      {8'd`CON_ROW_DNA,   8'd`CON_COL_DNA},
      {8'd`CON_ROW_MEM,   8'd`CON_COL_TEST},
      {8'd`CON_ROW_SDRAM, 8'd`CON_COL_TEST},
      {8'd`CON_ROW_SD,    8'd`CON_COL_TEST},
      {8'd`CON_ROW_FLASH, 8'd`CON_COL_TEST}
   };

   // ------------------------------
   // Message strings at 32..79
   // ------------------------------
   // Eight-byte slots padded with terminators
   localparam logic [0:5][0:7][7:0] MSG_TEXT = {
      {"VGA ",  {4{END_CHAR}}},
      {"NTSC",  {4{END_CHAR}}},
      {"PAL ",  {4{END_CHAR}}},
      {"wait ", {3{END_CHAR}}},
      {"OK   ", {3{END_CHAR}}},
      {"ERROR", {3{END_CHAR}}}
   };

   logic [2:0] msg_slot;

   assign msg_slot = 3'(addr[6:3] - 4'd4);

   always_comb begin
      data = END_CHAR;  // Unused entries read as terminator
      if (addr < 7'd24) begin
         case (addr[1:0])
            2'd0:    data = AT_CHAR;
            2'd1:    data = POS_RC[addr[4:2]][0];
            2'd2:    data = POS_RC[addr[4:2]][1];
            default: data = END_CHAR;
         endcase
      end else if (addr >= 7'd32 && addr < 7'd80) begin
         data = MSG_TEXT[msg_slot][addr[2:0]];
      end
   end

   // Hex digit to upper-case ASCII
   assign glyph = (digit < 4'd10) ? ZERO + {4'd0, digit} : ALPHA + {4'd0, digit};

endmodule

/* hdl/status_reporter.sv */
`timescale 1ns/1ps

`include "console_defs.svh"

module status_reporter (
   input  logic                    clk,
   input  logic                    arst_n,
   input  console_pkg::report_in_t report,
   output console_pkg::tele_byte_u tty_byte,
   output logic                    tty_valid,
   input  logic                    tty_credit
);
   import console_pkg::*;

   // String table entries
   localparam str_addr_t STR_POS_MODE  = 7'd0;
   localparam str_addr_t STR_POS_DNA   = 7'd4;
   localparam str_addr_t STR_POS_MEM   = 7'd8;
   localparam str_addr_t STR_POS_SDRAM = 7'd12;
   localparam str_addr_t STR_POS_SD    = 7'd16;
   localparam str_addr_t STR_POS_FLASH = 7'd20;
   localparam str_addr_t STR_VGA       = 7'd32;
   localparam str_addr_t STR_NTSC      = 7'd40;
   localparam str_addr_t STR_PAL       = 7'd48;
   localparam str_addr_t STR_WAIT      = 7'd56;
   localparam str_addr_t STR_OK        = 7'd64;
   localparam str_addr_t STR_ERROR     = 7'd72;

   localparam char_t      END_CHAR   = 8'd`CON_STR_END;
   localparam char_t      HOME_CHAR  = 8'd`CON_HOME;
   localparam logic [3:0] DNA_DIGITS = 4'(`CON_DNA_DIGITS);

   typedef enum logic [3:0] {
      ST_HOME,
      ST_MODE,
      ST_MODE_MSG,
      ST_DNA,
      ST_DNA_DIGIT,
      ST_TEST_POS,
      ST_TEST_MSG,
      ST_SEND_STR,   // Shared string walker
      ST_SEND_CHAR   // Shared byte sender
   } rep_state_t;

   rep_state_t   state;
   rep_state_t   ret_str;   // Where SEND_STR goes at the terminator
   rep_state_t   ret_char;  // Where SEND_CHAR goes after the byte
   str_addr_t    str_addr;
   str_addr_t    test_pos;
   char_t        tbl_data;
   char_t        glyph;
   char_t        chr;
   logic [59:0]  dna_sr;
   logic [3:0]   digit_cnt;
   logic [1:0]   test_idx;  // 0 mem, 1 sdram, 2 sd, 3 flash
   test_status_t test_st;
   logic         credit_cnt;
   logic         credit_avail;
   logic         send;

   string_table table_i (
      .addr  (str_addr),
      .digit (dna_sr[59:56]),
      .data  (tbl_data),
      .glyph (glyph)
   );

   // ------------------------------
   // Credit counter
   // ------------------------------
   assign credit_avail = credit_cnt | tty_credit;  // Returned credit usable at once
   assign send         = (state == ST_SEND_CHAR) && credit_avail;

   // Current test line
   always_comb begin
      case (test_idx)
         2'd0:    begin test_pos = STR_POS_MEM;   test_st = report.mem;   end
         2'd1:    begin test_pos = STR_POS_SDRAM; test_st = report.sdram; end
         2'd2:    begin test_pos = STR_POS_SD;    test_st = report.sd;    end
         default: begin test_pos = STR_POS_FLASH; test_st = report.flash; end
      endcase
   end

   always_ff @(posedge clk) begin
      if (send) begin
         tty_byte.code <= chr;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ST_HOME;
         ret_str    <= ST_MODE;
         ret_char   <= ST_MODE;
         str_addr   <= '0;
         chr        <= '0;
         dna_sr     <= '0;
         digit_cnt  <= '0;
         test_idx   <= '0;
         credit_cnt <= 1'b1;  // One credit after reset
         tty_valid  <= 1'b0;
      end else begin
         tty_valid  <= send;
         credit_cnt <= credit_avail & ~send;
         case (state)
            ST_HOME: begin  // Once after reset
               chr      <= HOME_CHAR;
               ret_char <= ST_MODE;
               state    <= ST_SEND_CHAR;
            end

            ST_MODE: begin
               str_addr <= STR_POS_MODE;
               ret_str  <= ST_MODE_MSG;
               state    <= ST_SEND_STR;
            end
            ST_MODE_MSG: begin
               if (report.video.vga)       str_addr <= STR_VGA;
               else if (report.video.ntsc) str_addr <= STR_NTSC;
               else                        str_addr <= STR_PAL;
               ret_str <= ST_DNA;
               state   <= ST_SEND_STR;
            end

            ST_DNA: begin
               str_addr  <= STR_POS_DNA;
               dna_sr    <= {3'b000, report.dna};
               digit_cnt <= '0;
               ret_str   <= ST_DNA_DIGIT;
               state     <= ST_SEND_STR;
            end
            ST_DNA_DIGIT: begin  // Most significant nibble first
               if (digit_cnt == DNA_DIGITS) begin
                  state <= ST_TEST_POS;
               end else begin
                  chr       <= glyph;
                  dna_sr    <= {dna_sr[55:0], 4'h0};
                  digit_cnt <= digit_cnt + 4'd1;
                  ret_char  <= ST_DNA_DIGIT;
                  state     <= ST_SEND_CHAR;
               end
            end

            ST_TEST_POS: begin
               str_addr <= test_pos;
               ret_str  <= ST_TEST_MSG;
               state    <= ST_SEND_STR;
            end
            ST_TEST_MSG: begin
               if (test_st.progress)    str_addr <= STR_WAIT;
               else if (test_st.result) str_addr <= STR_OK;
               else                     str_addr <= STR_ERROR;
               test_idx <= test_idx + 2'd1;
               ret_str  <= (test_idx == 2'd3) ? ST_MODE : ST_TEST_POS;  // Flash ends the pass
               state    <= ST_SEND_STR;
            end

            ST_SEND_STR: begin
               if (tbl_data == END_CHAR) begin
                  state <= ret_str;
               end else begin
                  chr      <= tbl_data;
                  str_addr <= str_addr + 7'd1;
                  ret_char <= ST_SEND_STR;
                  state    <= ST_SEND_CHAR;
               end
            end

            ST_SEND_CHAR: begin
               if (send) state <= ret_char;  // Stall here without credit
            end

            default: state <= ST_HOME;
         endcase
      end
   end

endmodule

/* hdl/status_console.sv */
`timescale 1ns/1ps

module status_console (
   input  logic                    clk,
   input  logic                    arst_n,
   input  console_pkg::report_in_t report,
   input  console_pkg::cell_addr_t read_addr,
   output console_pkg::char_t      read_char
);
   import console_pkg::*;

   // Reporter to teletype link
   tele_byte_u tty_byte;
   logic       tty_valid;
   logic       tty_credit;

   buf_write_t wr;  // Teletype to buffer

   status_reporter reporter_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .report     (report),
      .tty_byte   (tty_byte),
      .tty_valid  (tty_valid),
      .tty_credit (tty_credit)
   );

   teletype teletype_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .tty_byte   (tty_byte),
      .tty_valid  (tty_valid),
      .tty_credit (tty_credit),
      .wr         (wr)
   );

   // Read port stands in for the text renderer
   screen_buffer buffer_i (
      .clk       (clk),
      .wr        (wr),
      .read_addr (read_addr),
      .read_char (read_char)
   );

endmodule

/* tb/status_console_tb.sv */
`timescale 1ns/1ps

`include "console_defs.svh"

module status_console_tb;
   import console_pkg::*;

   localparam int CYCLE_LIMIT  = 12000;  // Clear, first screen and all update waits
   localparam int FIRST_SCREEN = 700;
   localparam int UPDATE_BOUND = 1300;   // Two report passes

   logic       clk;
   logic       arst_n;
   report_in_t report;
   report_in_t rpt;  // Next value for report
   cell_addr_t read_addr;
   char_t      read_char;

   integer seed;
   int     cycles     = 0;
   int     mismatches = 0;
   int     failures   = 0;

   status_console status_console_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .report    (report),
      .read_addr (read_addr),
      .read_char (read_char)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // ------------------------------
   // Run limit
   // ------------------------------
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   function automatic cell_addr_t cell_at(input int row, input int col);
      return cell_addr_t'(row * `CON_COLS + col);
   endfunction

   function automatic int test_row(input int i);
      case (i)
         0:       return `CON_ROW_MEM;
         1:       return `CON_ROW_SDRAM;
         2:       return `CON_ROW_SD;
         default: return `CON_ROW_FLASH;
      endcase
   endfunction

   // Expected screen text
   function automatic string video_text(input video_sel_t v);
      if (v.vga)       return "VGA ";
      else if (v.ntsc) return "NTSC";
      else             return "PAL ";
   endfunction

   function automatic string status_text(input test_status_t st);
      if (st.progress)    return "wait ";
      else if (st.result) return "OK   ";
      else                return "ERROR";
   endfunction

   function automatic string hex_text(input logic [56:0] id);
      logic [59:0] wide;
      string       s;
      wide = {3'b000, id};
      s    = $sformatf("%h", wide);  // 15 digits with leading zeros
      return s.toupper();
   endfunction

   function automatic test_status_t status_case(input int k);
      case (k)
         0:       return '{progress: 1'b1, result: 1'b1};  // Progress hides result
         1:       return '{progress: 1'b0, result: 1'b1};
         default: return '{progress: 1'b0, result: 1'b0};
      endcase
   endfunction

   task automatic set_test(input int i, input test_status_t st);
      case (i)
         0:       rpt.mem   = st;
         1:       rpt.sdram = st;
         2:       rpt.sd    = st;
         default: rpt.flash = st;
      endcase
   endtask

   task automatic apply_report();
      @(posedge clk);
      report <= rpt;
   endtask

   // Address goes out on one edge, data is back after the next
   task automatic read_cell(input cell_addr_t addr, output char_t c);
      @(posedge clk);
      read_addr <= addr;
      @(posedge clk);
      @(negedge clk);
      c = read_char;
   endtask

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_char(input cell_addr_t addr, input char_t got, input char_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: cell %0d (row %0d, column %0d) holds 0x%02h, expected 0x%02h",
                  $time, addr, addr / `CON_COLS, addr % `CON_COLS, got, exp);
      end
   endtask

   task automatic check_cell(input cell_addr_t addr, input char_t exp);
      char_t c;
      read_cell(addr, c);
      check_char(addr, c, exp);
   endtask

   task automatic check_text(input int row, input int col, input string text);
      for (int i = 0; i < text.len(); i++) begin
         check_cell(cell_at(row, col + i), char_t'(text[i]));
      end
   endtask

   task automatic field_matches(input int row, input int col, input string text,
                                output logic same);
      char_t c;
      same = 1'b1;
      for (int i = 0; i < text.len() && same; i++) begin
         read_cell(cell_at(row, col + i), c);
         if (c !== char_t'(text[i])) same = 1'b0;
      end
   endtask

   // Poll until the field shows the text, bounded by the update latency
   task automatic wait_for_text(input int row, input int col, input string text,
                                input int bound, input string what);
      int   start;
      logic same;
      start = cycles;
      same  = 1'b0;
      while (!same && (cycles - start) < bound) begin
         field_matches(row, col, text, same);
      end
      if (!same) begin
         failures++;
         $display("The %s field did not show \"%s\" within %0d cycles", what, text, bound);
      end
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic clear_after_reset();
      wait_for_text(`CON_ROW_MODE, `CON_COL_MODE, video_text(rpt.video), FIRST_SCREEN,
                    "video mode");
      for (int c = 0; c < `CON_COLS; c++) begin
         check_cell(cell_at(0, c), char_t'(`CON_SPACE));
         check_cell(cell_at(`CON_ROWS - 1, c), char_t'(`CON_SPACE));
      end
      for (int i = 0; i < 4; i++) begin
         check_cell(cell_at(test_row(i), `CON_COLS - 1), char_t'(`CON_SPACE));
      end
   endtask

   task automatic video_mode();
      for (int k = 0; k < 4; k++) begin  // PAL, VGA, NTSC, VGA over NTSC
         rpt.video = video_sel_t'({k[0], k[1]});
         apply_report();
         wait_for_text(`CON_ROW_MODE, `CON_COL_MODE, video_text(rpt.video), UPDATE_BOUND,
                       "video mode");
         check_text(`CON_ROW_MODE, `CON_COL_MODE, video_text(rpt.video));
      end
   endtask

   task automatic device_id();
      logic [63:0] r;
      for (int n = 0; n < 2; n++) begin
         r       = {$random(seed), $random(seed)};
         rpt.dna = r[56:0];
         apply_report();
         wait_for_text(`CON_ROW_DNA, `CON_COL_DNA, hex_text(rpt.dna), UPDATE_BOUND, "device ID");
         check_text(`CON_ROW_DNA, `CON_COL_DNA, hex_text(rpt.dna));
      end
   endtask

   // Each test sees wait, OK and ERROR across the three rounds
   task automatic test_results();
      for (int k = 0; k < 3; k++) begin
         for (int i = 0; i < 4; i++) set_test(i, status_case((i + k) % 3));
         apply_report();
         for (int i = 0; i < 4; i++) begin
            wait_for_text(test_row(i), `CON_COL_TEST, status_text(status_case((i + k) % 3)),
                          UPDATE_BOUND, "test result");
         end
         for (int i = 0; i < 4; i++) begin
            check_text(test_row(i), `CON_COL_TEST, status_text(status_case((i + k) % 3)));
         end
      end
   endtask

   task automatic rewrite_in_place();
      for (int k = 0; k < 3; k++) begin  // wait, OK, ERROR
         set_test(0, status_case(k));
         apply_report();
         wait_for_text(`CON_ROW_MEM, `CON_COL_TEST, status_text(rpt.mem), UPDATE_BOUND,
                       "memory test");
         check_text(`CON_ROW_MEM, `CON_COL_TEST, status_text(rpt.mem));
         check_cell(cell_at(`CON_ROW_MEM, `CON_COL_TEST - 1), char_t'(`CON_SPACE));
         check_cell(cell_at(`CON_ROW_MEM, `CON_COL_TEST + 5), char_t'(`CON_SPACE));
      end
   endtask

   initial begin
      seed = 56021;
      rpt  = '0;
      rpt.video.vga = 1'b1;
      for (int i = 0; i < 4; i++) set_test(i, status_case(0));
      arst_n    <= 1'b0;
      report    <= rpt;
      read_addr <= '0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      clear_after_reset();
      video_mode();
      device_id();
      test_results();
      rewrite_in_place();

      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+include
hdl/console_pkg.sv
hdl/screen_buffer.sv
hdl/teletype.sv
hdl/string_table.sv
hdl/status_reporter.sv
hdl/status_console.sv
tb/status_console_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the status console testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f sim.f --top-module status_console_tb \
   -Mdir obj_dir -o status_console_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/status_console_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1
